//--- build.f
+incdir+src
src/board_pkg.sv
src/key_debouncer.sv
src/slow_tick_gen.sv
src/i2s_mic_receiver.sv
src/seg_display_driver.sv
src/lab_top.sv
src/board_top.sv
testbench/tb_i2s_mic_model.sv
testbench/tb_board_top.sv

//--- src/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

//----------------------------------------
// Board clock and vector widths
//----------------------------------------

`define CLK_MHZ             27
`define W_KEY               2
`define W_LED               6
`define W_DIGIT             4
`define MIC_BITS            24

//----------------------------------------
// Default timing, in board clock cycles
//----------------------------------------

`define SLOW_DIV_DEFAULT    (`CLK_MHZ * 1000000)   // One tick per second
`define DEBOUNCE_DEFAULT    (`CLK_MHZ * 20000)     // 20 ms of stable level
`define SCK_HALF_DEFAULT    8                      // Bit clock near 1.7 MHz
`define SCAN_DEFAULT        (`CLK_MHZ * 1000)      // 1 ms per digit

`endif

//--- src/board_pkg.sv
`default_nettype none

`include "board_cfg.svh"

package board_pkg;

    // Keys after polarity fix, one bit per key
    typedef logic [`W_KEY   - 1:0] key_t;

    // LED vector, active high inside the design
    typedef logic [`W_LED   - 1:0] led_t;

    // Segments a to h, a in the top bit
    typedef logic [          7:0] seg_t;

    // One-hot digit select
    typedef logic [`W_DIGIT - 1:0] digit_sel_t;

    // Microphone sample in two's complement
    typedef logic signed [`MIC_BITS - 1:0] sample_t;

    // Lab counter and the word shown on the display
    typedef logic [         15:0] count_t;

endpackage

`default_nettype wire

//--- src/board_top.sv
`default_nettype none

`include "board_cfg.svh"

module board_top
#(
    parameter int unsigned slow_div        = `SLOW_DIV_DEFAULT,
    parameter int unsigned debounce_cycles = `DEBOUNCE_DEFAULT,
    parameter int unsigned sck_half        = `SCK_HALF_DEFAULT,
    parameter int unsigned scan_cycles     = `SCAN_DEFAULT
)
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire board_pkg::key_t   key,          // Active low
    output board_pkg::led_t        led,          // Active low
    output board_pkg::seg_t        hgfedcba,
    output board_pkg::digit_sel_t  digit,
    input  wire logic              mic_sd,
    output logic                   mic_sck,
    output logic                   mic_ws,
    output logic                   mic_lr
);

    board_pkg::key_t    key_pressed;
    board_pkg::led_t    lab_led;
    board_pkg::count_t  display_word;
    board_pkg::seg_t    abcdefgh;
    board_pkg::sample_t sample;
    logic               sample_valid;
    logic               tick;

    //----------------------------------------

    key_debouncer #(.debounce_cycles (debounce_cycles)) i_key_debouncer
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .key_raw      ( ~ key        ),
        .key_pressed  ( key_pressed  )
    );

    slow_tick_gen #(.slow_div (slow_div)) i_slow_tick_gen
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .tick         ( tick         )
    );

    i2s_mic_receiver #(.sck_half (sck_half)) i_microphone
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .mic_sd       ( mic_sd       ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    lab_top i_lab_top
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .tick         ( tick         ),
        .key_pressed  ( key_pressed  ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .display_word ( display_word ),
        .led          ( lab_led      )
    );

    seg_display_driver #(.scan_cycles (scan_cycles)) i_seg_display_driver
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .display_word ( display_word ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        )
    );

    //----------------------------------------

    assign led    = ~ lab_led;
    assign mic_lr = 1'b0;                        // Mic sends on the left slot

    // Pin bus runs h down to a
    for (genvar i = 0; i < $bits(board_pkg::seg_t); i++)
    begin : g_seg_reverse
        assign hgfedcba[i] = abcdefgh[$bits(board_pkg::seg_t) - 1 - i];
    end

endmodule

`default_nettype wire

//--- src/i2s_mic_receiver.sv
`default_nettype none

`include "board_cfg.svh"

module i2s_mic_receiver
#(
    parameter int unsigned sck_half = `SCK_HALF_DEFAULT
)
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            mic_sd,
    output logic                 mic_sck,
    output logic                 mic_ws,
    output board_pkg::sample_t   sample,
    output logic                 sample_valid
);

    localparam int half_w = $clog2(sck_half + 1);

    logic [half_w - 1:0]    half_cnt;      // Cycles within one half of the bit clock
    logic [4:0]             bit_cnt;       // Bit slot within the 32-bit frame
    logic                   sck_edge;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   capture_bit;
    logic                   capture_done;
    logic [`MIC_BITS - 1:0] shift_reg;

    assign sck_edge = (half_cnt == half_w'(sck_half - 1));
    assign sck_rise = sck_edge & ~mic_sck;
    assign sck_fall = sck_edge &  mic_sck;

    // Left frame only, bits 1 to 24 after the word select edge
    assign capture_bit = sck_rise & ~mic_ws
                       & (bit_cnt >= 5'd1) & (bit_cnt <= 5'(`MIC_BITS));

    //----------------------------------------
    // Bit clock and word select
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            half_cnt <= '0;
            mic_sck  <= 1'b0;
            bit_cnt  <= '0;
            mic_ws   <= 1'b0;
        end
        else
        begin
            if (sck_edge)
            begin
                half_cnt <= '0;
                mic_sck  <= ~mic_sck;
            end
            else
                half_cnt <= half_cnt + 1'b1;

            // Word select moves on a falling bit clock edge, like the mic expects
            if (sck_fall)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 5'd31)
                    mic_ws <= ~mic_ws;
            end
        end
    end

    //----------------------------------------
    // Sample capture
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (capture_bit)
            shift_reg <= {shift_reg[`MIC_BITS - 2:0], mic_sd};   // MSB first
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            capture_done <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            capture_done <= capture_bit & (bit_cnt == 5'(`MIC_BITS));
            sample_valid <= capture_done;
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture_done)
            sample <= board_pkg::sample_t'(shift_reg);   // Published with the strobe
    end

endmodule

`default_nettype wire

//--- src/key_debouncer.sv
`default_nettype none

`include "board_cfg.svh"

module key_debouncer
#(
    parameter int unsigned debounce_cycles = `DEBOUNCE_DEFAULT
)
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire board_pkg::key_t   key_raw,
    output board_pkg::key_t        key_pressed
);

    localparam int cnt_w = $clog2(debounce_cycles + 1);

    board_pkg::key_t  sync_meta;                   // First synchronizer stage
    board_pkg::key_t  sync_key;                    // Second synchronizer stage
    logic [cnt_w - 1:0] stable_cnt [`W_KEY];       // Cycles spent at a new level

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_meta <= '0;
            sync_key  <= '0;
        end
        else
        begin
            sync_meta <= key_raw;
            sync_key  <= sync_meta;
        end
    end

    // Each key has its own stability counter
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_pressed <= '0;
            for (int i = 0; i < `W_KEY; i++)
                stable_cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < `W_KEY; i++)
            begin
                if (sync_key[i] == key_pressed[i])
                    stable_cnt[i] <= '0;                       // Glitch over, start again
                else if (stable_cnt[i] == cnt_w'(debounce_cycles - 1))
                begin
                    key_pressed[i] <= sync_key[i];             // Level held long enough
                    stable_cnt[i]  <= '0;
                end
                else
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/lab_top.sv
`default_nettype none

`include "board_cfg.svh"

module lab_top
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               tick,
    input  wire board_pkg::key_t    key_pressed,
    input  wire board_pkg::sample_t sample,
    input  wire logic               sample_valid,
    output board_pkg::count_t       display_word,
    output board_pkg::led_t         led
);

    localparam int w_word = $bits(board_pkg::count_t);

    board_pkg::count_t  tick_count;
    board_pkg::sample_t mic_sample;
    logic               clear_key;
    logic               mic_mode;

    assign clear_key = key_pressed[1];
    assign mic_mode  = key_pressed[0];

    //----------------------------------------
    // Tick counter and sample latch
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
            tick_count <= '0;
        else if (clear_key)
            tick_count <= '0;                        // Held at zero while pressed
        else if (tick)
            tick_count <= tick_count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            mic_sample <= '0;
        else if (sample_valid)
            mic_sample <= sample;
    end

    //----------------------------------------
    // Display mode and LED level bar
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            display_word <= '0;
            led          <= '0;
        end
        else
        begin
            if (mic_mode)
                display_word <= mic_sample[`MIC_BITS - 1 -: w_word];   // Top of the sample
            else
                display_word <= tick_count;

            led <= mic_sample[`MIC_BITS - 1 -: `W_LED];   // Sign and loudest bits
        end
    end

endmodule

`default_nettype wire

//--- src/seg_display_driver.sv
`default_nettype none

`include "board_cfg.svh"

module seg_display_driver
#(
    parameter int unsigned scan_cycles = `SCAN_DEFAULT
)
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire board_pkg::count_t display_word,
    output board_pkg::seg_t        abcdefgh,
    output board_pkg::digit_sel_t  digit
);

    localparam int dwell_w = $clog2(scan_cycles + 1);
    localparam int idx_w   = $clog2(`W_DIGIT);

    logic [dwell_w - 1:0] dwell_cnt;
    logic [idx_w   - 1:0] digit_idx;
    logic [idx_w   - 1:0] next_idx;
    logic                 dwell_end;
    logic [3:0]           nibble;

    // Segments a to g, decimal point off
    function automatic board_pkg::seg_t hex_to_seg(input logic [3:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    assign dwell_end = (dwell_cnt == dwell_w'(scan_cycles - 1));

    always_comb
    begin
        next_idx = digit_idx;
        if (dwell_end)
            next_idx = (digit_idx == idx_w'(`W_DIGIT - 1)) ? '0 : digit_idx + 1'b1;
    end

    assign nibble = display_word[{next_idx, 2'b00} +: 4];   // Nibble 0 is least significant

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dwell_cnt <= '0;
            digit_idx <= '0;
            digit     <= board_pkg::digit_sel_t'(1);          // Digit 0 first
        end
        else
        begin
            dwell_cnt <= dwell_end ? '0 : dwell_cnt + 1'b1;
            digit_idx <= next_idx;
            digit     <= board_pkg::digit_sel_t'(1) << next_idx;
        end
    end

    // Registered with the select so both change in the same cycle
    always_ff @(posedge clk)
        abcdefgh <= hex_to_seg(nibble);

endmodule

`default_nettype wire

//--- src/slow_tick_gen.sv
`default_nettype none

`include "board_cfg.svh"

module slow_tick_gen
#(
    parameter int unsigned slow_div = `SLOW_DIV_DEFAULT
)
(
    input  wire logic clk,
    input  wire logic reset,
    output logic      tick
);

    localparam int cnt_w = $clog2(slow_div + 1);

    logic [cnt_w - 1:0] div_cnt;

    // Wraps at slow_div, so the tick is a single-cycle strobe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end
        else if (div_cnt == cnt_w'(slow_div - 1))
        begin
            div_cnt <= '0;
            tick    <= 1'b1;            // First pulse slow_div cycles after reset
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_board_top.sv
`default_nettype none

`include "board_cfg.svh"

module tb_board_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int slow_div        = 50;
    localparam int debounce_cycles = 6;
    localparam int sck_half        = 2;
    localparam int scan_cycles     = 4;

    localparam int frame_cycles = 32 * 2 * sck_half;          // One word select level
    localparam int read_max     = 6 * `W_DIGIT * scan_cycles;  // Worst wait for a stable read
    localparam int count_gap    = 70;
    localparam int count_reads  = 6;
    localparam int glitch_len   = 3;
    localparam int clear_hold   = 80;
    localparam int mic_words    = 4;

    localparam int len_reset   = 8 + read_max;
    localparam int len_count   = count_reads * (count_gap + read_max);
    localparam int len_glitch  = glitch_len + 3 * (count_gap + read_max);
    localparam int len_clear   = clear_hold + count_gap + 2 * read_max;
    localparam int len_mic     = (mic_words + 2) * 2 * frame_cycles;
    localparam int cycle_limit = 2 * (len_reset + len_count + len_glitch + len_clear + len_mic);

    logic                   clk;
    logic                   reset;
    board_pkg::key_t        key;
    board_pkg::led_t        led;
    board_pkg::seg_t        hgfedcba;
    board_pkg::digit_sel_t  digit;
    logic                   mic_sd;
    logic                   mic_sck;
    logic                   mic_ws;
    logic                   mic_lr;
    logic [`MIC_BITS - 1:0] mic_word;
    int                     mic_word_count;

    int                     cycle = 0;
    int                     release_cycle;
    int                     key_release;
    int                     seen_count;
    board_pkg::count_t      word;
    board_pkg::count_t      prev_word;
    board_pkg::led_t        expected_led;

    // Display decoder state
    board_pkg::count_t      scan_word  = '0;
    board_pkg::count_t      last_scan  = '0;
    board_pkg::count_t      shown_word = '0;
    int                     shown_count = 0;
    logic                   have_scan  = 1'b0;
    int                     digit_idx;
    int                     prev_idx   = 0;
    int                     nibble_val;

    // Bit clock and word select tracking
    int                     sck_run  = -1;         // Cycles since the last mic_sck change
    int                     ws_run   = -1;         // Cycles since the last mic_ws change
    logic                   sck_last = 1'b0;
    logic                   ws_last  = 1'b0;

    board_top
    #(
        .slow_div        ( slow_div        ),
        .debounce_cycles ( debounce_cycles ),
        .sck_half        ( sck_half        ),
        .scan_cycles     ( scan_cycles     )
    )
    board_top_inst
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .key      ( key      ),
        .led      ( led      ),
        .hgfedcba ( hgfedcba ),
        .digit    ( digit    ),
        .mic_sd   ( mic_sd   ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   )
    );

    tb_i2s_mic_model mic_model
    (
        .clk        ( clk            ),
        .mic_sck    ( mic_sck        ),
        .mic_ws     ( mic_ws         ),
        .mic_sd     ( mic_sd         ),
        .last_word  ( mic_word       ),
        .word_count ( mic_word_count )
    );

    //----------------------------------------
    // Reference and helpers
    //----------------------------------------

    // Hex glyph with segment a in the top bit reversed onto the h..a pin order
    function automatic board_pkg::seg_t seg_pins(input logic [3:0] nibble);
        board_pkg::seg_t abc;
        board_pkg::seg_t pins;
        case (nibble)
            4'h0:    abc = 8'hfc;
            4'h1:    abc = 8'h60;
            4'h2:    abc = 8'hda;
            4'h3:    abc = 8'hf2;
            4'h4:    abc = 8'h66;
            4'h5:    abc = 8'hb6;
            4'h6:    abc = 8'hbe;
            4'h7:    abc = 8'he0;
            4'h8:    abc = 8'hfe;
            4'h9:    abc = 8'hf6;
            4'ha:    abc = 8'hee;
            4'hb:    abc = 8'h3e;
            4'hc:    abc = 8'h9c;
            4'hd:    abc = 8'h7a;
            4'he:    abc = 8'h9e;
            default: abc = 8'h8e;
        endcase
        for (int i = 0; i < 8; i++)
            pins[i] = abc[7 - i];
        return pins;
    endfunction

    function automatic int decode_nibble(input board_pkg::seg_t pins);
        int value;
        value = -1;                                    // No glyph matched
        for (int n = 0; n < 16; n++)
            if (seg_pins(4'(n)) === pins)
                value = n;
        return value;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // Reports the violated bound when the value lies outside lo to hi
    task automatic check_range(input string name, input int value, input int lo,
                               input int hi);
        if (value < lo)
            check_value(name, value, lo);
        else if (value > hi)
            check_value(name, value, hi);
    endtask

    // Waits for the decoder to publish a fresh stable word
    task automatic read_shown_word(output board_pkg::count_t value);
        int start;
        start = shown_count;
        @(posedge clk);
        while (shown_count == start)
            @(posedge clk);
        value = shown_word;
    endtask

    // One tick every slow_div cycles and never below the last read
    task automatic check_tick_count(input board_pkg::count_t value,
                                    input board_pkg::count_t floor_word);
        int hi;
        int lo;
        hi = (cycle - release_cycle) / slow_div;
        lo = hi - 1;
        if (lo < int'(floor_word))
            lo = int'(floor_word);
        check_range("display_word", int'(value), lo, hi);
    endtask

    //----------------------------------------
    // Clock, cycle limit and display decoder
    //----------------------------------------

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit)
        begin
            $display("Run timed out after %0d cycles", cycle_limit);
            abort_run();
        end
    end

    always @(negedge clk)
    begin
        if (reset)
        begin
            prev_idx  = 0;
            have_scan = 1'b0;
        end
        else
        begin
            check_value("mic_lr", mic_lr, 0);
            digit_idx = -1;
            for (int i = 0; i < `W_DIGIT; i++)
                if (digit == board_pkg::digit_sel_t'(1 << i))
                    digit_idx = i;
            nibble_val = decode_nibble(hgfedcba);
            if (digit_idx < 0)
            begin
                $display("Digit select 0x%0h is not one-hot", digit);
                abort_run();
            end
            else if (nibble_val < 0)
            begin
                $display("Segment pins 0x%0h show no hex digit", hgfedcba);
                abort_run();
            end
            else
            begin
                if (digit_idx != prev_idx)
                    check_value("digit", digit,
                                board_pkg::digit_sel_t'(1) << ((prev_idx + 1) % `W_DIGIT));
                if (digit_idx == 0 && prev_idx == `W_DIGIT - 1)
                begin
                    if (have_scan && scan_word == last_scan)   // Two equal scans in a row
                    begin
                        shown_word  <= scan_word;
                        shown_count <= shown_count + 1;
                    end
                    last_scan = scan_word;
                    have_scan = 1'b1;
                end
                scan_word[digit_idx * 4 +: 4] = 4'(nibble_val);
                prev_idx = digit_idx;
            end
        end
    end

    // Half periods of the bit clock and word select, timed from their second change on
    always @(negedge clk)
    begin
        if (reset)
        begin
            sck_run = -1;
            ws_run  = -1;
        end
        else
        begin
            if (sck_run >= 0)
                sck_run = sck_run + 1;
            if (ws_run >= 0)
                ws_run = ws_run + 1;
            if (mic_sck !== sck_last)
            begin
                if (sck_run >= 0)
                    check_value("mic_sck half period", sck_run, sck_half);
                sck_run = 0;
            end
            if (mic_ws !== ws_last)
            begin
                if (ws_run >= 0)
                    check_value("mic_ws half period", ws_run, frame_cycles);
                ws_run = 0;
            end
            sck_last = mic_sck;
            ws_last  = mic_ws;
        end
    end

    //----------------------------------------
    // Stimulus
    //----------------------------------------

    initial
    begin
        reset = 1'b1;
        key   = '1;                                    // Pins idle high so nothing is pressed
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        release_cycle = cycle;

        // Reset state
        @(posedge clk);
        check_value("led", led, board_pkg::led_t'('1));
        check_value("mic_sck", mic_sck, 0);
        check_value("mic_ws", mic_ws, 0);
        read_shown_word(word);
        check_value("display_word", word, 0);

        // Free running tick count
        prev_word = '0;
        for (int i = 0; i < count_reads; i++)
        begin
            repeat (count_gap) @(posedge clk);
            read_shown_word(word);
            check_tick_count(word, prev_word);
            prev_word = word;
        end

        // Short pulse on key 1 must not clear
        key[1] <= 1'b0;
        repeat (glitch_len) @(posedge clk);
        key[1] <= 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            repeat (count_gap) @(posedge clk);
            read_shown_word(word);
            check_tick_count(word, prev_word);
            prev_word = word;
        end

        // Counter clear on key 1
        key[1] <= 1'b0;
        repeat (clear_hold / 2) @(posedge clk);
        read_shown_word(word);
        check_value("display_word", word, 0);
        repeat (clear_hold / 2) @(posedge clk);
        key[1] <= 1'b1;
        key_release = cycle;
        repeat (count_gap) @(posedge clk);
        read_shown_word(word);
        check_range("display_word", int'(word), 0, (cycle - key_release) / slow_div + 1);

        // Microphone level on display and LEDs
        key[0] <= 1'b0;
        for (int i = 0; i < mic_words; i++)
        begin
            seen_count = mic_word_count;
            while (mic_word_count == seen_count)
                @(posedge clk);
            expected_led = ~mic_word[`MIC_BITS - 1 -: `W_LED];
            repeat (frame_cycles) @(posedge clk);
            check_value("led", led, expected_led);
            read_shown_word(word);
            check_value("display_word", word, mic_word[`MIC_BITS - 1 -: 16]);
        end
        key[0] <= 1'b1;

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_i2s_mic_model.sv
`default_nettype none

`include "board_cfg.svh"

module tb_i2s_mic_model
(
    input  wire logic               clk,
    input  wire logic               mic_sck,
    input  wire logic               mic_ws,
    output logic                    mic_sd,
    output logic [`MIC_BITS - 1:0]  last_word,
    output int                      word_count
);

    timeunit 1ns;
    timeprecision 1ps;

    integer                 seed     = 67427;
    logic                   sck_seen = 1'b0;       // Bit clock one cycle ago
    logic                   ws_seen  = 1'b0;       // Word select one cycle ago
    logic [`MIC_BITS - 1:0] word     = '0;
    int                     bit_pos  = `MIC_BITS;  // Idle until the first left frame

    initial
    begin
        mic_sd     = 1'b0;
        last_word  = '0;
        word_count = 0;
    end

    // Reacts one board cycle after each falling bit clock edge
    always @(posedge clk)
    begin
        sck_seen <= mic_sck;
        ws_seen  <= mic_ws;
        if (sck_seen && !mic_sck)
        begin
            if (ws_seen && !mic_ws)
            begin
                word    <= `MIC_BITS'($random(seed));   // New word for this left frame
                bit_pos <= 0;
                mic_sd  <= 1'b0;                        // Slot 0 carries no data
            end
            else if (!mic_ws && bit_pos < `MIC_BITS)
            begin
                mic_sd  <= word[`MIC_BITS - 1 - bit_pos];   // MSB first
                bit_pos <= bit_pos + 1;
                if (bit_pos == `MIC_BITS - 1)
                begin
                    last_word  <= word;
                    word_count <= word_count + 1;
                end
            end
            else
                mic_sd <= 1'b0;
        end
    end

endmodule

`default_nettype wire
